//--- rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0]  regIdxT;
	typedef logic [3:0]  aluOpT;
	typedef logic [4:0]  shamtT;

	localparam logic [5:0] OpSpecial  = 6'd0;
	localparam logic [5:0] OpSpecial2 = 6'd28;
	localparam logic [5:0] OpAddi     = 6'd8;
	localparam logic [5:0] OpAddiu    = 6'd9;
	localparam logic [5:0] OpSlti     = 6'd10;
	localparam logic [5:0] OpSltiu    = 6'd11;
	localparam logic [5:0] OpAndi     = 6'd12;
	localparam logic [5:0] OpOri      = 6'd13;
	localparam logic [5:0] OpXori     = 6'd14;
	localparam logic [5:0] OpLui      = 6'd15;

	// SPECIAL funct field
	localparam logic [5:0] FnSll  = 6'd0;
	localparam logic [5:0] FnSrl  = 6'd2;
	localparam logic [5:0] FnSra  = 6'd3;
	localparam logic [5:0] FnSllv = 6'd4;
	localparam logic [5:0] FnSrlv = 6'd6;
	localparam logic [5:0] FnSrav = 6'd7;
	localparam logic [5:0] FnMovz = 6'd10;
	localparam logic [5:0] FnAdd  = 6'd32;
	localparam logic [5:0] FnAddu = 6'd33;
	localparam logic [5:0] FnSub  = 6'd34;
	localparam logic [5:0] FnSubu = 6'd35;
	localparam logic [5:0] FnAnd  = 6'd36;
	localparam logic [5:0] FnOr   = 6'd37;
	localparam logic [5:0] FnXor  = 6'd38;
	localparam logic [5:0] FnNor  = 6'd39;
	localparam logic [5:0] FnSlt  = 6'd42;
	localparam logic [5:0] FnSltu = 6'd43;
	localparam logic [5:0] FnClz  = 6'd32; // SPECIAL2
	localparam logic [5:0] FnClo  = 6'd33; // SPECIAL2

	localparam aluOpT AluAnd  = 4'd0;
	localparam aluOpT AluOr   = 4'd1;
	localparam aluOpT AluAdd  = 4'd2;
	localparam aluOpT AluNor  = 4'd3;
	localparam aluOpT AluXor  = 4'd4;
	localparam aluOpT AluSub  = 4'd6;
	localparam aluOpT AluSlt  = 4'd7;
	localparam aluOpT AluLui  = 4'd9;
	localparam aluOpT AluSll  = 4'd10;
	localparam aluOpT AluClo  = 4'd11;
	localparam aluOpT AluClz  = 4'd12;
	localparam aluOpT AluSrl  = 4'd13;
	localparam aluOpT AluSltu = 4'd14;
	localparam aluOpT AluSra  = 4'd15;

	localparam logic [7:0] IssueAddr = 8'h00;
	localparam int RegWindowBit = 7; // Set for register reads

	typedef struct packed {
		logic  regWrite;
		aluOpT aluOp;
		logic  useImm;
		logic  signImm;
		logic  useShamt; // Shift by shamt, not rs
		logic  isMovz;
	} ctrlT;

	typedef struct packed {
		logic   valid;
		ctrlT   ctrl;
		regIdxT destIdx;
		wordT   opA;
		wordT   opB;
	} exBundleT;

	typedef struct packed {
		logic   valid;
		regIdxT destIdx;
		wordT   data;
	} wbBundleT;

	typedef struct packed {
		logic       pSel;
		logic       pEnable;
		logic       pWrite;
		logic [7:0] pAddr;
		wordT       pWData;
	} apbReqT;

	// True when the instruction in EX will retire with a register write
	function automatic logic writesReg(exBundleT e);
		return e.valid && e.ctrl.regWrite && (e.destIdx != '0) &&
			(!e.ctrl.isMovz || (e.opB == '0));
	endfunction

endpackage

`default_nettype wire

//--- rtl/apbPort.sv
`timescale 1ns/1ns
`default_nettype none

module apbPort import mipsPkg::*; (
	input  wire logic   Clk,
	input  wire logic   rstN,
	input  wire apbReqT apbReq,
	output wordT        pRData,
	output logic        pReady,
	output regIdxT      dbgIdx,
	input  wire wordT   dbgData,
	output logic        idValid,
	output wordT        idInstr
);

	logic access;
	logic inWindow;
	logic issue;
	logic regRead;

	assign access   = apbReq.pSel && apbReq.pEnable;
	assign inWindow = apbReq.pAddr[RegWindowBit];

	// Issue space is everything below the register window
	assign issue   = access && apbReq.pWrite &&
		(inWindow == IssueAddr[RegWindowBit]);
	assign regRead = access && !apbReq.pWrite && inWindow;

	assign dbgIdx = apbReq.pAddr[6:2]; // Word addressed
	assign pRData = regRead ? dbgData : '0;
	assign pReady = 1'b1; // No wait states

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			idValid <= 1'b0;
		end else begin
			idValid <= issue;
		end
		if (issue) begin
			idInstr <= apbReq.pWData;
		end
	end

	// Access phase must follow a setup phase
	apbSetupFirst: assert property (
		@(posedge Clk) disable iff (!rstN)
		apbReq.pEnable |-> $past(apbReq.pSel)
	) else $error("APB access phase without setup");

endmodule

`default_nettype wire

//--- rtl/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder import mipsPkg::*; (
	input  wire wordT idInstr,
	output ctrlT      ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = idInstr[31:26];
	assign funct  = idInstr[5:0];

	always_comb begin
		ctrl = '0;
		case (opcode)
			OpSpecial: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					FnAdd, FnAddu: ctrl.aluOp = AluAdd; // No overflow trap
					FnSub, FnSubu: ctrl.aluOp = AluSub;
					FnAnd:  ctrl.aluOp = AluAnd;
					FnOr:   ctrl.aluOp = AluOr;
					FnXor:  ctrl.aluOp = AluXor;
					FnNor:  ctrl.aluOp = AluNor;
					FnSlt:  ctrl.aluOp = AluSlt;
					FnSltu: ctrl.aluOp = AluSltu;
					FnSll: begin
						ctrl.aluOp    = AluSll;
						ctrl.useShamt = 1'b1;
					end
					FnSrl: begin
						ctrl.aluOp    = AluSrl;
						ctrl.useShamt = 1'b1;
					end
					FnSra: begin
						ctrl.aluOp    = AluSra;
						ctrl.useShamt = 1'b1;
					end
					FnSllv: ctrl.aluOp = AluSll; // Amount from rs
					FnSrlv: ctrl.aluOp = AluSrl;
					FnSrav: ctrl.aluOp = AluSra;
					FnMovz: ctrl.isMovz = 1'b1;
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			OpSpecial2: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					FnClz:   ctrl.aluOp = AluClz;
					FnClo:   ctrl.aluOp = AluClo;
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			OpAddi, OpAddiu: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.signImm  = 1'b1;
				ctrl.aluOp    = AluAdd;
			end
			OpSlti, OpSltiu: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.signImm  = 1'b1; // SLTIU too, compare is unsigned
				ctrl.aluOp    = (opcode == OpSlti) ? AluSlt : AluSltu;
			end
			OpAndi, OpOri, OpXori: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				case (opcode)
					OpAndi:  ctrl.aluOp = AluAnd;
					OpOri:   ctrl.aluOp = AluOr;
					default: ctrl.aluOp = AluXor;
				endcase
			end
			OpLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm   = 1'b1;
				ctrl.aluOp    = AluLui;
			end
			default: ctrl = '0; // Retires with no effect
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/operandMux.sv
`timescale 1ns/1ns
`default_nettype none

module operandMux import mipsPkg::*; (
	input  wire logic     Clk,
	input  wire logic     rstN,
	input  wire logic     idValid,
	input  wire wordT     idInstr,
	input  wire ctrlT     ctrl,
	input  wire wordT     rsData,
	input  wire wordT     rtData,
	output regIdxT        rsIdx,
	output regIdxT        rtIdx,
	input  wire exBundleT exFwd,
	input  wire wordT     exResult,
	input  wire wbBundleT wbFwd,
	output exBundleT      ex
);

	wordT  rsVal, rtVal, imm;
	shamtT shAmt;
	logic  isShift;

	// EX beats WB, WB beats the register file
	function automatic wordT fwdValue(regIdxT idx, wordT rfData, exBundleT e,
			wordT eResult, wbBundleT w);
		if (idx == '0)
			return '0;
		if (writesReg(e) && (e.destIdx == idx))
			return eResult;
		if (w.valid && (w.destIdx == idx))
			return w.data;
		return rfData;
	endfunction

	assign rsIdx = idInstr[25:21];
	assign rtIdx = idInstr[20:16];

	assign rsVal = fwdValue(rsIdx, rsData, exFwd, exResult, wbFwd);
	assign rtVal = fwdValue(rtIdx, rtData, exFwd, exResult, wbFwd);

	assign imm = ctrl.signImm ? {{16{idInstr[15]}}, idInstr[15:0]} : {16'h0, idInstr[15:0]};

	assign isShift = (ctrl.aluOp == AluSll) || (ctrl.aluOp == AluSrl) ||
		(ctrl.aluOp == AluSra);
	assign shAmt   = ctrl.useShamt ? idInstr[10:6] : rsVal[4:0];

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			ex.valid <= 1'b0;
		end else begin
			ex.valid <= idValid;
		end
		ex.ctrl    <= ctrl;
		ex.destIdx <= ctrl.useImm ? rtIdx : idInstr[15:11];
		ex.opA     <= isShift ? rtVal : rsVal; // Shifted value is rt
		ex.opB     <= isShift ? {27'h0, shAmt} : (ctrl.useImm ? imm : rtVal);
	end

endmodule

`default_nettype wire

//--- rtl/aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit import mipsPkg::*; (
	input  wire logic     Clk,
	input  wire logic     rstN,
	input  wire exBundleT ex,
	output wordT          exResult,
	output wbBundleT      wb
);

	wordT  aluOut;
	wordT  opA, opB;
	shamtT sh;

	// Scans from bit 0 so the highest set bit wins
	function automatic wordT leadZeros(wordT v);
		wordT n;
		n = 32'd32;
		for (int i = 0; i < 32; i++) begin
			if (v[i])
				n = 32'(31 - i);
		end
		return n;
	endfunction

	assign opA = ex.opA;
	assign opB = ex.opB;
	assign sh  = opB[4:0];

	always_comb begin
		case (ex.ctrl.aluOp)
			AluAnd:  aluOut = opA & opB;
			AluOr:   aluOut = opA | opB;
			AluAdd:  aluOut = opA + opB;
			AluNor:  aluOut = ~(opA | opB);
			AluXor:  aluOut = opA ^ opB;
			AluSub:  aluOut = opA - opB;
			AluSlt:  aluOut = {31'h0, $signed(opA) < $signed(opB)};
			AluSltu: aluOut = {31'h0, opA < opB};
			AluSll:  aluOut = opA << sh;
			AluSrl:  aluOut = opA >> sh;
			AluSra:  aluOut = $signed(opA) >>> sh;
			AluClz:  aluOut = leadZeros(opA);
			AluClo:  aluOut = leadZeros(~opA);
			AluLui:  aluOut = {opB[15:0], 16'h0};
			default: aluOut = '0;
		endcase
	end

	// MOVZ copies rs through untouched
	assign exResult = ex.ctrl.isMovz ? opA : aluOut;

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= writesReg(ex); // Includes the MOVZ condition
		end
		wb.destIdx <= ex.destIdx;
		wb.data    <= exResult;
	end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile import mipsPkg::*; (
	input  wire logic     Clk,
	input  wire logic     rstN,
	input  wire regIdxT   rsIdx,
	input  wire regIdxT   rtIdx,
	input  wire regIdxT   dbgIdx,
	output wordT          rsData,
	output wordT          rtData,
	output wordT          dbgData,
	input  wire wbBundleT wb
);

	wordT regs [32];

	// Pending write shows through on the same cycle
	function automatic wordT readPort(regIdxT idx, wordT stored, wbBundleT w);
		if (idx == '0)
			return '0;
		return (w.valid && (w.destIdx == idx)) ? w.data : stored;
	endfunction

	assign rsData  = readPort(rsIdx, regs[rsIdx], wb);
	assign rtData  = readPort(rtIdx, regs[rtIdx], wb);
	assign dbgData = readPort(dbgIdx, regs[dbgIdx], wb);

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb.valid) begin
			regs[wb.destIdx] <= wb.data;
		end
	end

	// Commit port must never target r0
	r0StaysZero: assert property (
		@(posedge Clk) disable iff (!rstN)
		$past(rstN) |-> (regs[0] == '0)
	) else $error("register 0 corrupted");

endmodule

`default_nettype wire

//--- rtl/cpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTop import mipsPkg::*; (
	input  wire logic     Clk,
	input  wire logic     rstN,
	input  wire apbReqT   apbReq,
	output wordT          pRData,
	output logic          pReady,
	output wbBundleT      commit
);

	logic     idValid;
	wordT     idInstr;
	ctrlT     ctrl;
	regIdxT   rsIdx, rtIdx, dbgIdx;
	wordT     rsData, rtData, dbgData;
	exBundleT exStage;
	wordT     exResult;

	apbPort uApb (
		.Clk     (Clk),
		.rstN    (rstN),
		.apbReq  (apbReq),
		.pRData  (pRData),
		.pReady  (pReady),
		.dbgIdx  (dbgIdx),
		.dbgData (dbgData),
		.idValid (idValid),
		.idInstr (idInstr)
	);

	instrDecoder uDec (
		.idInstr (idInstr),
		.ctrl    (ctrl)
	);

	operandMux uOpMux (
		.Clk      (Clk),
		.rstN     (rstN),
		.idValid  (idValid),
		.idInstr  (idInstr),
		.ctrl     (ctrl),
		.rsData   (rsData),
		.rtData   (rtData),
		.rsIdx    (rsIdx),
		.rtIdx    (rtIdx),
		.exFwd    (exStage),
		.exResult (exResult),
		.wbFwd    (commit),
		.ex       (exStage)
	);

	aluUnit uAlu (
		.Clk      (Clk),
		.rstN     (rstN),
		.ex       (exStage),
		.exResult (exResult),
		.wb       (commit)
	);

	regFile uRegs (
		.Clk     (Clk),
		.rstN    (rstN),
		.rsIdx   (rsIdx),
		.rtIdx   (rtIdx),
		.dbgIdx  (dbgIdx),
		.rsData  (rsData),
		.rtData  (rtData),
		.dbgData (dbgData),
		.wb      (commit)
	);

endmodule

`default_nettype wire

//--- sim/tbModel.svh
`ifndef TBMODEL_SVH
`define TBMODEL_SVH

wordT modelRegs [32];

function automatic wordT countLeading(wordT v, logic bitVal);
	wordT n;
	logic inRun;
	n = '0;
	inRun = 1'b1;
	for (int i = 31; i >= 0; i--) begin
		if (inRun && (v[i] == bitVal))
			n = n + 1;
		else
			inRun = 1'b0;
	end
	return n;
endfunction

// Kinds 0..16 SPECIAL, 17..18 SPECIAL2, 19..26 immediate
function automatic wordT encodeOp(int k, regIdxT rs, regIdxT rt, regIdxT rd,
		shamtT sh, logic [15:0] imm);
	logic [5:0] opc;
	logic [5:0] fn;
	opc = OpSpecial;
	fn = '0;
	if ((k == 17) || (k == 18))
		opc = OpSpecial2;
	case (k)
		0:  fn = FnAdd;
		1:  fn = FnAddu;
		2:  fn = FnSub;
		3:  fn = FnSubu;
		4:  fn = FnAnd;
		5:  fn = FnOr;
		6:  fn = FnXor;
		7:  fn = FnNor;
		8:  fn = FnSlt;
		9:  fn = FnSltu;
		10: fn = FnSll;
		11: fn = FnSrl;
		12: fn = FnSra;
		13: fn = FnSllv;
		14: fn = FnSrlv;
		15: fn = FnSrav;
		16: fn = FnMovz;
		17: fn = FnClz;
		18: fn = FnClo;
		19: opc = OpAddi;
		20: opc = OpAddiu;
		21: opc = OpSlti;
		22: opc = OpSltiu;
		23: opc = OpAndi;
		24: opc = OpOri;
		25: opc = OpXori;
		default: opc = OpLui;
	endcase
	if (k >= 19)
		return {opc, rs, rt, imm};
	if (k >= 17)
		return {opc, rs, rt, rd, 5'd0, fn};
	return {opc, rs, rt, rd, sh, fn};
endfunction

// Register fields come from v, offset by base
function automatic wordT randomInstr(int k, wordT v, regIdxT base);
	return encodeOp(k, 5'(v[2:0]) + base, 5'(v[5:3]) + base, 5'(v[8:6]) + base,
		v[13:9], v[31:16]);
endfunction

// Returns 1 when the instruction writes a register
function automatic logic execModel(input wordT instr, output regIdxT dest, output wordT val);
	logic [5:0] opc;
	logic [5:0] fn;
	wordT a, b, sImm, zImm;
	shamtT sh;
	logic wr;
	opc = instr[31:26];
	fn = instr[5:0];
	a = modelRegs[instr[25:21]];
	b = modelRegs[instr[20:16]];
	sh = instr[10:6];
	sImm = {{16{instr[15]}}, instr[15:0]};
	zImm = {16'h0, instr[15:0]};
	dest = instr[15:11];
	val = '0;
	wr = 1'b1;
	case (opc)
		OpSpecial: begin
			case (fn)
				FnAdd, FnAddu: val = a + b;
				FnSub, FnSubu: val = a - b;
				FnAnd:  val = a & b;
				FnOr:   val = a | b;
				FnXor:  val = a ^ b;
				FnNor:  val = ~(a | b);
				FnSlt:  val = {31'h0, ($signed(a) < $signed(b))};
				FnSltu: val = {31'h0, (a < b)};
				FnSll:  val = b << sh;
				FnSrl:  val = b >> sh;
				FnSra:  val = $signed(b) >>> sh;
				FnSllv: val = b << a[4:0];
				FnSrlv: val = b >> a[4:0];
				FnSrav: val = $signed(b) >>> a[4:0];
				FnMovz: begin
					val = a;
					wr = (b == '0);
				end
				default: wr = 1'b0;
			endcase
		end
		OpSpecial2: begin
			case (fn)
				FnClz:   val = countLeading(a, 1'b0);
				FnClo:   val = countLeading(a, 1'b1);
				default: wr = 1'b0;
			endcase
		end
		default: begin
			dest = instr[20:16]; // Immediates write rt
			case (opc)
				OpAddi, OpAddiu: val = a + sImm;
				OpSlti:  val = {31'h0, ($signed(a) < $signed(sImm))};
				OpSltiu: val = {31'h0, (a < sImm)};
				OpAndi:  val = a & zImm;
				OpOri:   val = a | zImm;
				OpXori:  val = a ^ zImm;
				OpLui:   val = {instr[15:0], 16'h0};
				default: wr = 1'b0;
			endcase
		end
	endcase
	if (dest == '0)
		wr = 1'b0;
	if (wr)
		modelRegs[dest] = val;
	return wr;
endfunction

`endif

//--- sim/tbTop.sv
`timescale 1ns/1ns
`default_nettype none

module tbTop import mipsPkg::*; ();

	localparam int NumSetup = 12;
	localparam int NumDirected = 27;
	localparam int NumOddballs = 9;
	localparam int NumRandom = 300;
	// Reset, three full register sweeps, spaced issues, back-to-back issues, drains
	localparam int MaxCycles = 10 + 3 * 32 * 3 + (NumSetup + NumDirected + NumOddballs) * 5 +
		NumRandom * 2 + 3 * 20 + 200;

	typedef struct {
		regIdxT dest;
		wordT   data;
		int     at;
	} expectT;

	logic     Clk = 1'b0;
	logic     rstN;
	apbReqT   apbReq;
	wordT     pRData;
	logic     pReady;
	wbBundleT commit;

	integer seed;
	int     cycles = 0;
	int     errors = 0;
	int     testsPassed = 0;
	int     testsFailed = 0;
	expectT expQ [$];
	expectT head;

	`include "tbModel.svh"

	cpuTop DUT (
		.Clk    (Clk),
		.rstN   (rstN),
		.apbReq (apbReq),
		.pRData (pRData),
		.pReady (pReady),
		.commit (commit)
	);

	always #50 Clk = ~Clk;

	always @(posedge Clk) begin
		cycles <= cycles + 1;
		if (cycles > MaxCycles) begin
			$display("Timeout: run exceeded %0d cycles", MaxCycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic compareValues(input wordT got, input wordT exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Commit port sampled mid-cycle
	always @(negedge Clk) begin
		if (rstN && commit.valid) begin
			if (expQ.size() == 0) begin
				$display("Commit to r%0d at %0t was not expected", commit.destIdx, $time);
				errors++;
			end else begin
				head = expQ.pop_front();
				compareValues(32'(commit.destIdx), 32'(head.dest), "commit register");
				compareValues(commit.data, head.data, "commit data");
				compareValues(cycles - head.at, 32'd3, "commit latency");
			end
		end
	end

	task automatic idleBus(input int n);
		@(posedge Clk);
		#5;
		apbReq = '0;
		repeat (n) @(posedge Clk);
	endtask

	task automatic issueInstr(input wordT instr);
		regIdxT d;
		wordT v;
		@(posedge Clk);
		#5;
		apbReq = '{pSel: 1'b1, pEnable: 1'b0, pWrite: 1'b1, pAddr: IssueAddr, pWData: instr};
		@(posedge Clk);
		#5;
		apbReq.pEnable = 1'b1; // Access phase
		if (execModel(instr, d, v))
			expQ.push_back('{dest: d, data: v, at: cycles});
	endtask

	task automatic readReg(input regIdxT idx, output wordT data);
		@(posedge Clk);
		#5;
		apbReq = '{pSel: 1'b1, pEnable: 1'b0, pWrite: 1'b0, pAddr: {1'b1, idx, 2'b00},
			pWData: '0};
		@(posedge Clk);
		#5;
		apbReq.pEnable = 1'b1;
		@(negedge Clk);
		data = pRData;
		compareValues(32'(pReady), 32'd1, "pReady");
	endtask

	task automatic waitDrain();
		idleBus(1);
		while (expQ.size() != 0) @(posedge Clk);
		idleBus(4); // Lets non-writing instructions leave too
	endtask

	task automatic checkAllRegs();
		wordT v;
		for (int i = 0; i < 32; i++) begin
			readReg(5'(i), v);
			compareValues(v, modelRegs[i], $sformatf("register r%0d", i));
		end
		idleBus(1);
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errors == errBefore) begin
			$display("Test %s: ok", name);
			testsPassed++;
		end else begin
			$display("Test %s: %0d errors", name, errors - errBefore);
			testsFailed++;
		end
	endtask

	initial begin
		wordT v, w;
		int errBefore;
		seed = 32'hfc90a6bc;
		apbReq = '0;
		rstN = 1'b0;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		repeat (10) @(posedge Clk);
		#5;
		rstN = 1'b1;

		errBefore = errors;
		checkAllRegs();
		reportTest("reset state", errBefore);

		errBefore = errors;
		for (int r = 1; r <= 4; r++) begin
			v = $random(seed);
			issueInstr({OpLui, 5'd0, 5'(r), v[31:16]});
			idleBus(2);
			issueInstr({OpOri, 5'(r), 5'(r), v[15:0]});
			idleBus(2);
		end
		for (int r = 5; r <= 8; r++) begin
			v = $random(seed);
			issueInstr({OpAddiu, 5'd0, 5'(r), v[15:0]});
			idleBus(2);
		end
		for (int k = 0; k < NumDirected; k++) begin
			v = $random(seed);
			issueInstr(randomInstr(k, v, 5'd1));
			idleBus(2);
		end
		waitDrain();
		reportTest("directed instructions", errBefore);

		errBefore = errors;
		for (int i = 0; i < NumRandom; i++) begin
			v = $random(seed);
			w = $random(seed);
			issueInstr(randomInstr(int'(w % 27), v, 5'd0)); // Registers r0..r7
		end
		waitDrain();
		reportTest("back-to-back forwarding", errBefore);

		errBefore = errors;
		v = $random(seed);
		issueInstr({OpLui, 5'd0, 5'd9, 16'h8001}); // Nonzero rt for MOVZ
		idleBus(2);
		issueInstr({OpAddiu, 5'd1, 5'd0, v[15:0]});
		idleBus(2);
		issueInstr({OpSpecial, 5'd1, 5'd2, 5'd0, 5'd0, FnAddu});
		idleBus(2);
		issueInstr({OpLui, 5'd0, 5'd0, v[31:16]});
		idleBus(2);
		issueInstr({OpSpecial, 5'd1, 5'd9, 5'd10, 5'd0, FnMovz});
		idleBus(2);
		issueInstr(32'h0);
		idleBus(2);
		issueInstr({6'h3f, v[25:0]});
		idleBus(2);
		issueInstr({OpSpecial, 5'd1, 5'd2, 5'd3, 5'd0, 6'd1});
		idleBus(2);
		issueInstr({OpSpecial2, 5'd1, 5'd2, 5'd3, 5'd0, 6'd0});
		waitDrain();
		checkAllRegs();
		reportTest("no-effect instructions", errBefore);

		errBefore = errors;
		waitDrain();
		checkAllRegs();
		reportTest("final register state", errBefore);

		$display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+sim
rtl/mipsPkg.sv
rtl/apbPort.sv
rtl/instrDecoder.sv
rtl/operandMux.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/cpuTop.sv
sim/tbTop.sv

//--- run.sh
#!/bin/bash
# Builds the MIPS core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tbTop -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	exit 1
fi
exit 0
